/* compile.f */
logic/rtos_pkg.sv
logic/rtos_task.sv
logic/rtos_ready_queue.sv
logic/rtos_sync.sv
logic/rtos_core.sv
test/tb_clock.sv
test/tb_rtos.sv

/* logic/rtos_core.sv */
`timescale 1ns/1ps

module rtos_core
    import rtos_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  svc_t       svc,
    input  logic       time_tick,
    output tskid_t     run_tskid,
    output logic       run_valid,
    output task_view_t task_view [NUM_TASKS],
    output semcnt_t    semcnt,
    output flgptn_t    flgptn,
    output logic       busy
);

    logic [NUM_TASKS-1:0] rdq_add_req;
    logic [NUM_TASKS-1:0] rdq_add_ack;
    logic [NUM_TASKS-1:0] rdq_rmv;
    logic [NUM_TASKS-1:0] timeout_req;
    logic [NUM_TASKS-1:0] timeout_ack;
    logic [NUM_TASKS-1:0] rel_tsk;
    tskpri_t              task_pri [NUM_TASKS];

    assign busy = (|rdq_add_req) || (|timeout_req);

    // ----------------------------------------------------------------------
    // task blocks
    // ----------------------------------------------------------------------
    for (genvar i = 0; i < NUM_TASKS; i++) begin : g_task
        logic sel;
        logic run_sel;

        assign sel         = (svc.tskid == tskid_t'(i));
        // wait calls act on the running task
        assign run_sel     = run_valid && (run_tskid == tskid_t'(i));
        assign task_pri[i] = task_view[i].tskpri;

        rtos_task #(.TSKID(tskid_t'(i))) u_task (
            .clk(clk), .reset(reset), .time_tick(time_tick),
            .chg_pri(sel && svc.op == SVC_CHG_PRI),
            .wup_tsk(sel && svc.op == SVC_WUP_TSK),
            .slp_tsk(sel && svc.op == SVC_SLP_TSK),
            .sus_tsk(sel && svc.op == SVC_SUS_TSK),
            .rsm_tsk(sel && svc.op == SVC_RSM_TSK),
            .dly_tsk(sel && svc.op == SVC_DLY_TSK),
            .rel_wai(sel && svc.op == SVC_REL_WAI),
            .wai_sem(run_sel && svc.op == SVC_WAI_SEM),
            .wai_flg(run_sel && svc.op == SVC_WAI_FLG),
            .set_tmo(sel && svc.op == SVC_SET_TMO),
            .svc_tskpri(svc.tskpri), .svc_reltim(svc.reltim),
            .svc_flgptn(svc.flgptn), .svc_wfmode(svc.wfmode),
            .run_valid(run_sel), .flgptn(flgptn), .rel_tsk(rel_tsk[i]),
            .rdq_add_ack(rdq_add_ack[i]), .timeout_ack(timeout_ack[i]),
            .rdq_add_req(rdq_add_req[i]), .rdq_rmv(rdq_rmv[i]),
            .timeout_req(timeout_req[i]), .view(task_view[i])
        );
    end

    rtos_ready_queue u_ready_queue (
        .clk(clk), .reset(reset), .add_req(rdq_add_req), .rmv(rdq_rmv),
        .tskpri(task_pri), .add_ack(rdq_add_ack),
        .run_tskid(run_tskid), .run_valid(run_valid)
    );

    rtos_sync u_sync (
        .clk(clk), .reset(reset),
        .sig_sem(svc.op == SVC_SIG_SEM),
        .wai_sem(run_valid && svc.op == SVC_WAI_SEM), .wai_tskid(run_tskid),
        .set_flg(svc.op == SVC_SET_FLG), .clr_flg(svc.op == SVC_CLR_FLG),
        .svc_flgptn(svc.flgptn), .timeout_req(timeout_req),
        .rel_tsk(rel_tsk), .timeout_ack(timeout_ack),
        .semcnt(semcnt), .flgptn(flgptn)
    );

endmodule

/* logic/rtos_pkg.sv */
package rtos_pkg;

    localparam int NUM_TASKS  = 4;
    localparam int TSKID_W    = 2;
    localparam int TSKPRI_W   = 4;
    localparam int RELTIM_W   = 16;
    localparam int FLGPTN_W   = 4;
    localparam int SEMCNT_W   = 3;
    localparam int MAX_WUPCNT = 1;
    localparam int MAX_SUSCNT = 1;
    localparam int SEM_INIT   = 0;

    typedef logic [TSKID_W-1:0]  tskid_t;
    // lower value runs first
    typedef logic [TSKPRI_W-1:0] tskpri_t;
    typedef logic [RELTIM_W-1:0] reltim_t;
    typedef logic [FLGPTN_W-1:0] flgptn_t;
    typedef logic [SEMCNT_W-1:0] semcnt_t;

    typedef enum logic signed [7:0] {
        E_OK    = 8'sd0,
        E_OBJ   = -8'sd41,
        E_QOVR  = -8'sd43,
        E_RLWAI = -8'sd49,
        E_TMOUT = -8'sd50
    } er_t;

    typedef enum logic [3:0] {
        TTS_RUN = 4'h1,
        TTS_RDY = 4'h2,
        TTS_WAI = 4'h4,
        TTS_SUS = 4'h8,
        TTS_WAS = 4'hc
    } tskstat_t;

    // bit positions, combined into one nibble
    typedef enum logic [3:0] {
        TTW_DLY = 4'h1,
        TTW_SLP = 4'h2,
        TTW_SEM = 4'h4,
        TTW_FLG = 4'h8
    } tskwait_t;

    typedef enum logic [3:0] {
        SVC_NOP, SVC_CHG_PRI, SVC_WUP_TSK, SVC_SLP_TSK, SVC_SUS_TSK,
        SVC_RSM_TSK, SVC_DLY_TSK, SVC_REL_WAI, SVC_WAI_SEM, SVC_SIG_SEM,
        SVC_WAI_FLG, SVC_SET_FLG, SVC_CLR_FLG, SVC_SET_TMO
    } svc_op_t;

    typedef struct packed {
        svc_op_t op;
        tskid_t  tskid;
        tskpri_t tskpri;
        reltim_t reltim;
        flgptn_t flgptn;
        logic    wfmode;    // 0 and, 1 or
    } svc_t;

    typedef struct packed {
        tskstat_t                          tskstat;
        tskwait_t                          tskwait;
        logic [$clog2(MAX_WUPCNT+1)-1:0]   wupcnt;
        logic [$clog2(MAX_SUSCNT+1)-1:0]   suscnt;
        tskpri_t                           tskpri;
        er_t                               er;
    } task_view_t;

endpackage

/* logic/rtos_ready_queue.sv */
`timescale 1ns/1ps

module rtos_ready_queue
    import rtos_pkg::*;
(
    input  logic                 clk,
    input  logic                 reset,
    input  logic [NUM_TASKS-1:0] add_req,
    input  logic [NUM_TASKS-1:0] rmv,
    input  tskpri_t              tskpri [NUM_TASKS],
    output logic [NUM_TASKS-1:0] add_ack,
    output tskid_t               run_tskid,
    output logic                 run_valid
);

    logic [NUM_TASKS-1:0] ready;
    tskid_t               best_id;
    tskpri_t              best_pri;
    logic                 best_ok;

    // one grant per cycle, lowest id
    assign add_ack = add_req & (~add_req + NUM_TASKS'(1));

    // ----------------------------------------------------------------------
    // ready bits
    // ----------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset)
            ready <= '0;
        else
            ready <= (ready | add_ack) & ~rmv;
    end

    // best ready task, ties to lowest id
    always_comb begin
        best_id  = '0;
        best_pri = '1;
        best_ok  = 1'b0;
        for (int i = 0; i < NUM_TASKS; i++) begin
            if (ready[i] && (!best_ok || tskpri[i] < best_pri)) begin
                best_ok  = 1'b1;
                best_id  = tskid_t'(i);
                best_pri = tskpri[i];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            run_tskid <= '0;
            run_valid <= 1'b0;
        end else begin
            run_tskid <= best_id;
            run_valid <= best_ok;
        end
    end

endmodule

/* logic/rtos_sync.sv */
`timescale 1ns/1ps

module rtos_sync
    import rtos_pkg::*;
(
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 sig_sem,
    input  logic                 wai_sem,
    input  tskid_t               wai_tskid,
    input  logic                 set_flg,
    input  logic                 clr_flg,
    input  flgptn_t              svc_flgptn,
    input  logic [NUM_TASKS-1:0] timeout_req,
    output logic [NUM_TASKS-1:0] rel_tsk,
    output logic [NUM_TASKS-1:0] timeout_ack,
    output semcnt_t              semcnt,
    output flgptn_t              flgptn
);

    logic [NUM_TASKS-1:0] waiters;
    logic [NUM_TASKS-1:0] eligible;
    logic [NUM_TASKS-1:0] first_waiter;
    logic [NUM_TASKS-1:0] caller;
    logic [NUM_TASKS-1:0] rel_next;
    logic [NUM_TASKS-1:0] add_next;

    // a waiter that is timing out is not released any more
    assign eligible     = waiters & ~timeout_req;
    assign first_waiter = eligible & (~eligible + NUM_TASKS'(1));
    assign caller       = NUM_TASKS'(1) << wai_tskid;

    always_comb begin
        rel_next = '0;
        add_next = '0;
        if (wai_sem) begin
            if (semcnt != '0)
                rel_next = caller;
            else
                add_next = caller;
        end else if (sig_sem) begin
            rel_next = first_waiter;
        end
    end

    // ----------------------------------------------------------------------
    // semaphore, waiter set and timeout acknowledge
    // ----------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            waiters     <= '0;
            rel_tsk     <= '0;
            timeout_ack <= '0;
            semcnt      <= semcnt_t'(SEM_INIT);
            flgptn      <= '0;
        end else begin
            waiters     <= (waiters & ~timeout_req & ~rel_next) | add_next;
            rel_tsk     <= rel_next;
            timeout_ack <= timeout_req & ~timeout_ack;

            if (wai_sem && semcnt != '0)
                semcnt <= semcnt - 1'b1;
            else if (sig_sem && eligible == '0 && semcnt != '1)
                semcnt <= semcnt + 1'b1;

            // event flag
            if (set_flg)
                flgptn <= flgptn | svc_flgptn;
            else if (clr_flg)
                flgptn <= flgptn & svc_flgptn;
        end
    end

endmodule

/* logic/rtos_task.sv */
`timescale 1ns/1ps

module rtos_task
    import rtos_pkg::*;
#(
    parameter tskid_t TSKID = '0
) (
    input  logic       clk,
    input  logic       reset,
    input  logic       time_tick,

    input  logic       chg_pri,
    input  logic       wup_tsk,
    input  logic       slp_tsk,
    input  logic       sus_tsk,
    input  logic       rsm_tsk,
    input  logic       dly_tsk,
    input  logic       rel_wai,
    input  logic       wai_sem,
    input  logic       wai_flg,
    input  logic       set_tmo,

    input  tskpri_t    svc_tskpri,
    input  reltim_t    svc_reltim,
    input  flgptn_t    svc_flgptn,
    input  logic       svc_wfmode,

    input  logic       run_valid,
    input  flgptn_t    flgptn,
    input  logic       rel_tsk,
    input  logic       rdq_add_ack,
    input  logic       timeout_ack,

    output logic       rdq_add_req,
    output logic       rdq_rmv,
    output logic       timeout_req,
    output task_view_t view
);

    logic                              wai;
    logic                              sus;
    logic                              wait_dly;
    logic                              wait_slp;
    logic                              wait_sem;
    logic                              wait_flg;
    logic [$clog2(MAX_WUPCNT+1)-1:0]   wupcnt;
    logic [$clog2(MAX_SUSCNT+1)-1:0]   suscnt;
    tskpri_t                           tskpri;
    er_t                               er;
    reltim_t                           tmr_cnt;
    logic                              tmr_en;
    flgptn_t                           flg_pat;
    logic                              flg_mode;

    logic                              flg_hit;
    logic                              tmo_hit;
    logic                              leave;
    er_t                               leave_er;

    // ----------------------------------------------------------------------
    // wait release conditions
    // ----------------------------------------------------------------------
    always_comb begin
        if (flg_mode)
            flg_hit = wait_flg && ((flgptn & flg_pat) != '0);
        else
            flg_hit = wait_flg && ((flgptn & flg_pat) == flg_pat);
        tmo_hit = tmr_en && time_tick && (tmr_cnt <= reltim_t'(1));

        leave    = 1'b0;
        leave_er = E_OK;
        if (rel_wai && wai) begin
            leave    = 1'b1;
            leave_er = E_RLWAI;
        end else if (timeout_ack && wait_sem) begin
            leave    = 1'b1;
            leave_er = E_TMOUT;
        end else if (tmo_hit && !wait_sem) begin
            leave    = 1'b1;
            leave_er = E_TMOUT;
        end else if ((rel_tsk && wait_sem) || flg_hit || (wup_tsk && wait_slp)) begin
            leave = 1'b1;
        end
    end

    // ----------------------------------------------------------------------
    // control state
    // ----------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            wai         <= 1'b1;
            sus         <= 1'b0;
            wait_dly    <= 1'b0;
            wait_slp    <= 1'b1;
            wait_sem    <= 1'b0;
            wait_flg    <= 1'b0;
            wupcnt      <= '0;
            suscnt      <= '0;
            tskpri      <= tskpri_t'(TSKID);
            er          <= E_OK;
            tmr_en      <= 1'b0;
            rdq_add_req <= 1'b0;
            timeout_req <= 1'b0;
        end else begin
            if (rdq_add_ack)
                rdq_add_req <= 1'b0;

            if (leave) begin
                wai         <= 1'b0;
                wait_dly    <= 1'b0;
                wait_slp    <= 1'b0;
                wait_sem    <= 1'b0;
                wait_flg    <= 1'b0;
                tmr_en      <= 1'b0;
                rdq_add_req <= !sus;
                er          <= leave_er;
            end

            // semaphore waiter has to be taken off the waiter set first
            if (timeout_ack) begin
                timeout_req <= 1'b0;
            end else if (tmo_hit && wait_sem) begin
                timeout_req <= 1'b1;
                tmr_en      <= 1'b0;
            end

            if (chg_pri) begin
                tskpri <= svc_tskpri;
                er     <= E_OK;
            end else if (wup_tsk && !wait_slp) begin
                if (wupcnt != $bits(wupcnt)'(MAX_WUPCNT)) begin
                    wupcnt <= wupcnt + 1'b1;
                    er     <= E_OK;
                end else begin
                    er <= E_QOVR;
                end
            end else if (slp_tsk) begin
                if (wait_slp) begin
                    er <= E_OBJ;
                end else if (wupcnt != '0) begin
                    wupcnt <= wupcnt - 1'b1;
                    er     <= E_OK;
                end else begin
                    wai         <= 1'b1;
                    wait_slp    <= 1'b1;
                    rdq_add_req <= 1'b0;
                    er          <= E_OK;
                end
            end else if (sus_tsk) begin
                if (!sus) begin
                    sus         <= 1'b1;
                    rdq_add_req <= 1'b0;
                    er          <= E_OK;
                end else if (suscnt != $bits(suscnt)'(MAX_SUSCNT)) begin
                    suscnt <= suscnt + 1'b1;
                    er     <= E_OK;
                end else begin
                    er <= E_QOVR;
                end
            end else if (rsm_tsk) begin
                if (!sus) begin
                    er <= E_OBJ;
                end else if (suscnt != '0) begin
                    suscnt <= suscnt - 1'b1;
                    er     <= E_OK;
                end else begin
                    sus         <= 1'b0;
                    rdq_add_req <= !wai || leave;
                    er          <= E_OK;
                end
            end else if (dly_tsk) begin
                wai         <= 1'b1;
                wait_dly    <= 1'b1;
                tmr_en      <= 1'b1;
                rdq_add_req <= 1'b0;
            end else if (rel_wai && !wai) begin
                er <= E_OBJ;
            end else if (wai_sem) begin
                wai         <= 1'b1;
                wait_sem    <= 1'b1;
                rdq_add_req <= 1'b0;
            end else if (wai_flg) begin
                wai         <= 1'b1;
                wait_flg    <= 1'b1;
                rdq_add_req <= 1'b0;
            end else if (set_tmo && wai) begin
                tmr_en <= 1'b1;
            end
        end
    end

    // timer and flag pattern
    always_ff @(posedge clk) begin
        if (dly_tsk || (set_tmo && wai))
            tmr_cnt <= svc_reltim;
        else if (tmr_en && time_tick)
            tmr_cnt <= tmr_cnt - 1'b1;

        if (wai_flg) begin
            flg_pat  <= svc_flgptn;
            flg_mode <= svc_wfmode;
        end
    end

    // calls that take the task off the ready queue
    always_comb begin
        rdq_rmv = 1'b0;
        if (slp_tsk && !wait_slp && wupcnt == '0)
            rdq_rmv = 1'b1;
        if ((sus_tsk && !sus) || dly_tsk || wai_sem || wai_flg)
            rdq_rmv = 1'b1;
    end

    always_comb begin
        view.tskstat = tskstat_t'({sus, wai, !run_valid && !wai && !sus, run_valid});
        view.tskwait = tskwait_t'({wait_flg, wait_sem, wait_slp, wait_dly});
        view.wupcnt  = wupcnt;
        view.suscnt  = suscnt;
        view.tskpri  = tskpri;
        view.er      = er;
    end

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
# build the testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_rtos -f compile.f -o sim_rtos ||
    { echo "verilator build failed"; exit 1; }

output="$(./obj_dir/sim_rtos 2>&1)"
echo "$output"
echo "$output" | grep -q "TEST PASSED" && echo "simulation passed" ||
    { echo "simulation failed"; exit 1; }

/* test/tb_clock.sv */
`timescale 1ns/1ps

module tb_clock (
    output logic clk,
    output logic reset
);

    // 8 ns period
    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    initial begin
        reset <= 1'b1;
        repeat (4) @(posedge clk);
        reset <= 1'b0;
    end

endmodule

/* test/tb_rtos.sv */
`timescale 1ns/1ps

module tb_rtos
    import rtos_pkg::*;
();

    // twice six behaviors of about 200 cycles each plus reset
    localparam int MAX_CYCLES = 2 * 6 * 200 + 600;
    // one grant per waiting task plus the timeout handshake
    localparam int MAX_BUSY_CYCLES = NUM_TASKS + 2;

    logic                 clk;
    logic                 reset;
    svc_t                 svc;
    logic                 time_tick;
    tskid_t               run_tskid;
    logic                 run_valid;
    task_view_t           task_view [NUM_TASKS];
    semcnt_t              semcnt;
    flgptn_t              flgptn;
    logic                 busy;
    int                   busy_cycles = 0;
    int                   seed = 32'ha26a_17f3;
    int                   cycle_count = 0;
    int                   n_ticks;

    tb_clock clock_gen (.clk(clk), .reset(reset));

    rtos_core dut0 (
        .clk(clk), .reset(reset), .svc(svc), .time_tick(time_tick),
        .run_tskid(run_tskid), .run_valid(run_valid), .task_view(task_view),
        .semcnt(semcnt), .flgptn(flgptn), .busy(busy)
    );

    task automatic abort_run();
        $display("TEST FAILED");
        $fatal(1, "simulation stopped at the first failure");
    endtask

    always @(posedge clk) begin
        busy_cycles <= busy ? busy_cycles + 1 : 0;
    end

    // ready queue and timeout handshakes end within a few cycles
    busy_bound_check: assert property (@(posedge clk) disable iff (reset)
        busy_cycles <= MAX_BUSY_CYCLES)
        else begin
            $display("%0t: busy stayed high for more than %0d cycles", $time,
                     MAX_BUSY_CYCLES);
            abort_run();
        end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count > MAX_CYCLES) begin
            $display("timeout: the run did not end within %0d cycles", MAX_CYCLES);
            abort_run();
        end
    end

    // ----------------------------------------------------------------------
    // checks
    // ----------------------------------------------------------------------
    task automatic expect_eq(input string name, input int got, input int exp);
        assert (got == exp)
            else begin
                $display("[ERROR] %0t: %s is %0d, expected %0d", $time, name, got, exp);
                abort_run();
            end
    endtask

    task automatic check_task(input tskid_t id, input tskstat_t stat, input logic [3:0] wt,
                              input er_t er);
        string pfx;
        pfx = $sformatf("task_view[%0d]", id);
        expect_eq({pfx, ".tskstat"}, int'(task_view[id].tskstat), int'(stat));
        expect_eq({pfx, ".tskwait"}, int'(task_view[id].tskwait), int'(wt));
        expect_eq({pfx, ".er"}, int'(task_view[id].er), int'(er));
    endtask

    task automatic check_counts(input tskid_t id, input int wup, input int sus, input int pri);
        string pfx;
        pfx = $sformatf("task_view[%0d]", id);
        expect_eq({pfx, ".wupcnt"}, int'(task_view[id].wupcnt), wup);
        expect_eq({pfx, ".suscnt"}, int'(task_view[id].suscnt), sus);
        expect_eq({pfx, ".tskpri"}, int'(task_view[id].tskpri), pri);
    endtask

    task automatic check_run(input logic valid, input tskid_t id);
        expect_eq("run_valid", int'(run_valid), int'(valid));
        if (valid)
            expect_eq("run_tskid", int'(run_tskid), int'(id));
    endtask

    task automatic check_sync(input semcnt_t cnt, input flgptn_t pat);
        expect_eq("semcnt", int'(semcnt), int'(cnt));
        expect_eq("flgptn", int'(flgptn), int'(pat));
    endtask

    // ----------------------------------------------------------------------
    // stimulus
    // ----------------------------------------------------------------------
    // wait for the ready queue and timeout handshakes to finish
    task automatic settle();
        repeat (3) @(negedge clk);
        while (busy)
            @(negedge clk);
        repeat (2) @(negedge clk);
    endtask

    task automatic issue(input svc_op_t op, input tskid_t id, input tskpri_t pri = '0,
                         input reltim_t tim = '0, input flgptn_t pat = '0,
                         input logic mode = 1'b0);
        svc_t call;
        call        = '0;
        call.op     = op;
        call.tskid  = id;
        call.tskpri = pri;
        call.reltim = tim;
        call.flgptn = pat;
        call.wfmode = mode;
        @(posedge clk);
        svc <= call;
        @(posedge clk);
        svc <= '0;
        settle();
    endtask

    // one-cycle tick pulses with a random gap
    task automatic tick(input int count);
        int gap;
        repeat (count) begin
            @(posedge clk);
            time_tick <= 1'b1;
            @(posedge clk);
            time_tick <= 1'b0;
            gap = int'($unsigned($random(seed)) % 4);
            repeat (gap) @(posedge clk);
        end
        settle();
    endtask

    initial begin
        svc       <= '0;
        time_tick <= 1'b0;
        @(negedge reset);
        @(negedge clk);

        for (int i = 0; i < NUM_TASKS; i++) begin
            check_task(tskid_t'(i), TTS_WAI, TTW_SLP, E_OK);
            check_counts(tskid_t'(i), 0, 0, i);
        end
        check_run(1'b0, 2'd0);
        expect_eq("busy", int'(busy), 0);
        check_sync(semcnt_t'(SEM_INIT), 4'd0);

        issue(SVC_WUP_TSK, 2'd2);
        check_task(2'd2, TTS_RUN, 4'h0, E_OK);
        check_run(1'b1, 2'd2);
        issue(SVC_WUP_TSK, 2'd1);
        check_run(1'b1, 2'd1);
        issue(SVC_CHG_PRI, 2'd1, 4'd9);
        check_counts(2'd1, 0, 0, 9);
        check_task(2'd1, TTS_RDY, 4'h0, E_OK);
        check_run(1'b1, 2'd2);

        // wake-up nesting on the running task
        issue(SVC_WUP_TSK, 2'd2);
        check_counts(2'd2, 1, 0, 2);
        issue(SVC_WUP_TSK, 2'd2);
        check_task(2'd2, TTS_RUN, 4'h0, E_QOVR);
        issue(SVC_SLP_TSK, 2'd2);
        check_counts(2'd2, 0, 0, 2);
        check_task(2'd2, TTS_RUN, 4'h0, E_OK);
        issue(SVC_SLP_TSK, 2'd2);
        check_task(2'd2, TTS_WAI, TTW_SLP, E_OK);
        check_run(1'b1, 2'd1);
        issue(SVC_SLP_TSK, 2'd2);
        check_task(2'd2, TTS_WAI, TTW_SLP, E_OBJ);

        // suspend and resume
        issue(SVC_SUS_TSK, 2'd1);
        check_task(2'd1, TTS_SUS, 4'h0, E_OK);
        check_run(1'b0, 2'd0);
        issue(SVC_SUS_TSK, 2'd3);
        check_task(2'd3, TTS_WAS, TTW_SLP, E_OK);
        issue(SVC_WUP_TSK, 2'd3);
        check_task(2'd3, TTS_SUS, 4'h0, E_OK);
        issue(SVC_SUS_TSK, 2'd3);
        check_counts(2'd3, 0, 1, 3);
        issue(SVC_RSM_TSK, 2'd3);
        check_task(2'd3, TTS_SUS, 4'h0, E_OK);
        check_counts(2'd3, 0, 0, 3);
        issue(SVC_RSM_TSK, 2'd3);
        check_task(2'd3, TTS_RUN, 4'h0, E_OK);
        check_run(1'b1, 2'd3);
        issue(SVC_RSM_TSK, 2'd3);
        check_task(2'd3, TTS_RUN, 4'h0, E_OBJ);
        issue(SVC_RSM_TSK, 2'd1);
        check_task(2'd1, TTS_RDY, 4'h0, E_OK);
        check_run(1'b1, 2'd3);

        // ----------------------------------------------------------------------
        // delay, semaphore and event flag on task 3
        // ----------------------------------------------------------------------
        n_ticks = 1 + int'($unsigned($random(seed)) % 8);
        issue(SVC_DLY_TSK, 2'd3, 4'd0, reltim_t'(n_ticks));
        check_task(2'd3, TTS_WAI, TTW_DLY, E_OBJ);
        check_run(1'b1, 2'd1);
        tick(n_ticks - 1);
        check_task(2'd3, TTS_WAI, TTW_DLY, E_OBJ);
        tick(1);
        check_task(2'd3, TTS_RUN, 4'h0, E_TMOUT);
        check_run(1'b1, 2'd3);
        issue(SVC_DLY_TSK, 2'd3, 4'd0, 16'd100);
        issue(SVC_REL_WAI, 2'd3);
        check_task(2'd3, TTS_RUN, 4'h0, E_RLWAI);

        issue(SVC_WAI_SEM, 2'd0);
        check_task(2'd3, TTS_WAI, TTW_SEM, E_RLWAI);
        check_run(1'b1, 2'd1);
        issue(SVC_SIG_SEM, 2'd0);
        check_task(2'd3, TTS_RUN, 4'h0, E_OK);
        check_sync(3'd0, 4'd0);
        issue(SVC_SIG_SEM, 2'd0);
        check_sync(3'd1, 4'd0);
        // E_OBJ marks the release that follows
        issue(SVC_RSM_TSK, 2'd3);
        issue(SVC_WAI_SEM, 2'd0);
        check_task(2'd3, TTS_RUN, 4'h0, E_OK);
        check_sync(3'd0, 4'd0);

        n_ticks = 1 + int'($unsigned($random(seed)) % 8);
        issue(SVC_WAI_SEM, 2'd0);
        issue(SVC_SET_TMO, 2'd3, 4'd0, reltim_t'(n_ticks));
        tick(n_ticks - 1);
        check_task(2'd3, TTS_WAI, TTW_SEM, E_OK);
        tick(1);
        check_task(2'd3, TTS_RUN, 4'h0, E_TMOUT);
        issue(SVC_SIG_SEM, 2'd0);
        check_task(2'd3, TTS_RUN, 4'h0, E_TMOUT);
        check_sync(3'd1, 4'd0);

        // and-wait for 0101
        issue(SVC_WAI_FLG, 2'd0, 4'd0, 16'd0, 4'b0101, 1'b0);
        issue(SVC_SET_FLG, 2'd0, 4'd0, 16'd0, 4'b0001);
        check_task(2'd3, TTS_WAI, TTW_FLG, E_TMOUT);
        check_sync(3'd1, 4'b0001);
        issue(SVC_SET_FLG, 2'd0, 4'd0, 16'd0, 4'b0100);
        check_task(2'd3, TTS_RUN, 4'h0, E_OK);
        issue(SVC_RSM_TSK, 2'd3);
        // or-wait for 1000
        issue(SVC_WAI_FLG, 2'd0, 4'd0, 16'd0, 4'b1000, 1'b1);
        check_task(2'd3, TTS_WAI, TTW_FLG, E_OBJ);
        issue(SVC_SET_FLG, 2'd0, 4'd0, 16'd0, 4'b1000);
        check_task(2'd3, TTS_RUN, 4'h0, E_OK);
        check_sync(3'd1, 4'b1101);
        issue(SVC_CLR_FLG, 2'd0, 4'd0, 16'd0, 4'b0110);
        check_sync(3'd1, 4'b0100);

        $display("TEST PASSED");
        $finish;
    end

endmodule
